//--- streamer_defs.svh
`ifndef STREAMER_DEFS_SVH
`define STREAMER_DEFS_SVH

// Memory word and word address widths
`define STREAMER_DW 32
`define STREAMER_AW 16

// Length and stride fields of a channel configuration
`define STREAMER_LEN_W 16

// Load FIFOs cover the read latency plus a consumer that stalls for a while
`define STREAMER_LOAD_DEPTH 4
`define STREAMER_STORE_DEPTH 2

// X, W and Y load channels
`define STREAMER_N_SRC 3

`endif

//--- streamer_pkg.sv
`include "streamer_defs.svh"

package streamer_pkg;

  typedef logic [`STREAMER_DW-1:0]    word_t;
  typedef logic [`STREAMER_AW-1:0]    addr_t;
  typedef logic [`STREAMER_LEN_W-1:0] len_t;

  // One queued write of the store channel
  typedef struct packed {
    addr_t addr;
    word_t data;
  } store_req_t;

  // Load channels come first so they index the source arrays directly
  typedef enum logic [1:0] {
    CH_X = 2'd0,
    CH_W = 2'd1,
    CH_Y = 2'd2,
    CH_Z = 2'd3
  } chan_id_e;

endpackage : streamer_pkg

//--- streamer_fifo.sv
`timescale 1ns/1ps
`include "streamer_defs.svh"

module streamer_fifo
  import streamer_pkg::*;
#(
  parameter type         payload_t = word_t,
  parameter int unsigned DEPTH     = `STREAMER_LOAD_DEPTH,
  localparam int unsigned CNT_W    = $clog2(DEPTH + 1)
) (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             clear_i,
  input  logic             push_i,
  input  payload_t         data_i,
  output logic             full_o,
  input  logic             pop_i,
  output payload_t         data_o,
  output logic             empty_o,
  output logic [CNT_W-1:0] count_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign count_o = count_q;
  assign data_o  = mem_q[rd_ptr_q];

  // Requests against a full or empty buffer are dropped
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule : streamer_fifo

//--- stream_source.sv
`timescale 1ns/1ps
`include "streamer_defs.svh"

module stream_source
  import streamer_pkg::*;
(
  input  logic  clk_i,
  input  logic  arst_n_i,
  input  logic  clear_i,
  input  logic  start_i,
  input  addr_t base_i,
  input  len_t  len_i,
  input  len_t  stride_i,
  output logic  req_o,
  output addr_t add_o,
  input  logic  gnt_i,
  input  logic  rvalid_i,
  input  word_t rdata_i,
  output logic  valid_o,
  input  logic  ready_i,
  output word_t data_o,
  output logic  busy_o,
  output logic  done_o
);

  localparam int unsigned CNT_W = $clog2(`STREAMER_LOAD_DEPTH + 1);

  logic             busy_q;
  logic             done_q;
  addr_t            addr_q;
  len_t             stride_q;
  len_t             issue_rem_q;
  len_t             out_rem_q;
  logic [CNT_W-1:0] inflight_q;
  logic [CNT_W-1:0] fifo_count;
  logic [CNT_W:0]   credit_used;
  logic             fifo_empty;
  logic             req_fire;
  logic             pop;

  // A read may only go out if the FIFO is sure to have room when it returns
  assign credit_used = {1'b0, inflight_q} + {1'b0, fifo_count};
  assign req_o       = busy_q && (issue_rem_q != '0)
                       && (credit_used < (CNT_W + 1)'(`STREAMER_LOAD_DEPTH));
  assign add_o       = addr_q;
  assign req_fire    = req_o & gnt_i;

  assign valid_o = ~fifo_empty;
  assign pop     = valid_o & ready_i;
  assign busy_o  = busy_q;
  assign done_o  = done_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q      <= 1'b0;
      done_q      <= 1'b0;
      issue_rem_q <= '0;
      out_rem_q   <= '0;
    end else begin
      done_q <= 1'b0;
      if (clear_i) begin
        busy_q      <= 1'b0;
        issue_rem_q <= '0;
        out_rem_q   <= '0;
      end else if (start_i) begin
        // An empty run finishes at once
        busy_q      <= (len_i != '0);
        done_q      <= (len_i == '0);
        issue_rem_q <= len_i;
        out_rem_q   <= len_i;
      end else begin
        if (req_fire) begin
          issue_rem_q <= issue_rem_q - 1'b1;
        end
        if (pop && busy_q) begin
          out_rem_q <= out_rem_q - 1'b1;
          if (out_rem_q == len_t'(1)) begin
            busy_q <= 1'b0;
            done_q <= 1'b1;
          end
        end
      end
    end
  end

  // Reads granted but not yet returned
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      inflight_q <= '0;
    end else if (clear_i) begin
      inflight_q <= '0;
    end else begin
      case ({req_fire, rvalid_i})
        2'b10:   inflight_q <= inflight_q + 1'b1;
        2'b01:   inflight_q <= inflight_q - 1'b1;
        default: inflight_q <= inflight_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q   <= base_i;
      stride_q <= stride_i;
    end else if (req_fire) begin
      addr_q <= addr_q + addr_t'(stride_q);
    end
  end

  streamer_fifo #(
    .payload_t ( word_t               ),
    .DEPTH     ( `STREAMER_LOAD_DEPTH )
  ) i_load_fifo (
    .clk_i    ( clk_i      ),
    .arst_n_i ( arst_n_i   ),
    .clear_i  ( clear_i    ),
    .push_i   ( rvalid_i   ),
    .data_i   ( rdata_i    ),
    .full_o   (            ),
    .pop_i    ( pop        ),
    .data_o   ( data_o     ),
    .empty_o  ( fifo_empty ),
    .count_o  ( fifo_count )
  );

endmodule : stream_source

//--- stream_sink.sv
`timescale 1ns/1ps
`include "streamer_defs.svh"

module stream_sink
  import streamer_pkg::*;
(
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       clear_i,
  input  logic       start_i,
  input  addr_t      base_i,
  input  len_t       len_i,
  input  len_t       stride_i,
  input  logic       valid_i,
  output logic       ready_o,
  input  word_t      data_i,
  output logic       req_o,
  output store_req_t wreq_o,
  input  logic       gnt_i,
  output logic       busy_o,
  output logic       done_o
);

  logic       busy_q;
  logic       done_q;
  addr_t      addr_q;
  len_t       stride_q;
  len_t       acc_rem_q;
  len_t       wr_rem_q;
  store_req_t push_req;
  logic       fifo_full;
  logic       fifo_empty;
  logic       accept;
  logic       pop;

  assign ready_o = busy_q && (acc_rem_q != '0) && !fifo_full;
  assign accept  = valid_i & ready_o;

  // Each accepted word is bound to its write address right away
  assign push_req.addr = addr_q;
  assign push_req.data = data_i;

  assign req_o  = ~fifo_empty;
  assign pop    = req_o & gnt_i;
  assign busy_o = busy_q;
  assign done_o = done_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q    <= 1'b0;
      done_q    <= 1'b0;
      acc_rem_q <= '0;
      wr_rem_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (clear_i) begin
        busy_q    <= 1'b0;
        acc_rem_q <= '0;
        wr_rem_q  <= '0;
      end else if (start_i) begin
        busy_q    <= (len_i != '0);
        done_q    <= (len_i == '0);
        acc_rem_q <= len_i;
        wr_rem_q  <= len_i;
      end else begin
        if (accept) begin
          acc_rem_q <= acc_rem_q - 1'b1;
        end
        // Run ends with the grant of the last write
        if (pop && busy_q) begin
          wr_rem_q <= wr_rem_q - 1'b1;
          if (wr_rem_q == len_t'(1)) begin
            busy_q <= 1'b0;
            done_q <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q   <= base_i;
      stride_q <= stride_i;
    end else if (accept) begin
      addr_q <= addr_q + addr_t'(stride_q);
    end
  end

  streamer_fifo #(
    .payload_t ( store_req_t           ),
    .DEPTH     ( `STREAMER_STORE_DEPTH )
  ) i_store_fifo (
    .clk_i    ( clk_i      ),
    .arst_n_i ( arst_n_i   ),
    .clear_i  ( clear_i    ),
    .push_i   ( accept     ),
    .data_i   ( push_req   ),
    .full_o   ( fifo_full  ),
    .pop_i    ( pop        ),
    .data_o   ( wreq_o     ),
    .empty_o  ( fifo_empty ),
    .count_o  (            )
  );

endmodule : stream_sink

//--- ldst_arbiter.sv
`timescale 1ns/1ps
`include "streamer_defs.svh"

module ldst_arbiter
  import streamer_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       clear_i,
  input  logic                       z_priority_i,
  input  logic [`STREAMER_N_SRC-1:0] src_req_i,
  input  addr_t [`STREAMER_N_SRC-1:0] src_add_i,
  output logic [`STREAMER_N_SRC-1:0] src_gnt_o,
  output logic [`STREAMER_N_SRC-1:0] src_rvalid_o,
  output word_t                      rdata_o,
  input  logic                       st_req_i,
  input  store_req_t                 st_wreq_i,
  output logic                       st_gnt_o,
  output logic                       mem_req_o,
  output addr_t                      mem_add_o,
  output logic                       mem_wen_o,
  output word_t                      mem_data_o,
  input  logic                       mem_gnt_i,
  input  word_t                      mem_r_data_i
);

  localparam int unsigned N_SRC  = `STREAMER_N_SRC;
  localparam int unsigned SLOT_W = $clog2(N_SRC);

  // Round-robin slots are X, W and the Y/Z pair, so the Y slot is shared
  logic [N_SRC-1:0]  slot_req;
  logic              z_sel;
  logic              rr_found;
  logic [SLOT_W-1:0] rr_slot;
  logic [SLOT_W-1:0] rr_ptr_q;
  logic              win_store;
  chan_id_e          win_id;
  logic              grant;
  logic              tag_valid_q;
  chan_id_e          tag_id_q;

  // Store beats Y unless the priority force is set and Y is asking
  assign z_sel = st_req_i & ~(z_priority_i & src_req_i[CH_Y]);

  always_comb begin
    slot_req       = src_req_i;
    slot_req[CH_Y] = src_req_i[CH_Y] | st_req_i;
  end

  always_comb begin : rr_pick
    int unsigned idx;
    rr_found = 1'b0;
    rr_slot  = rr_ptr_q;
    for (int unsigned k = 0; k < N_SRC; k++) begin
      idx = int'(rr_ptr_q) + k;
      if (idx >= N_SRC) begin
        idx = idx - N_SRC;
      end
      if (!rr_found && slot_req[idx]) begin
        rr_found = 1'b1;
        rr_slot  = SLOT_W'(idx);
      end
    end
  end

  assign win_store = rr_found && (rr_slot == SLOT_W'(CH_Y)) && z_sel;
  assign win_id    = win_store ? CH_Z : chan_id_e'(rr_slot);

  // Port side is purely combinational
  assign mem_req_o  = rr_found;
  assign mem_add_o  = win_store ? st_wreq_i.addr : src_add_i[rr_slot];
  assign mem_wen_o  = ~win_store;
  assign mem_data_o = st_wreq_i.data;
  assign grant      = mem_req_o & mem_gnt_i;

  always_comb begin
    for (int unsigned i = 0; i < N_SRC; i++) begin
      src_gnt_o[i]    = grant & ~win_store & (rr_slot == SLOT_W'(i));
      src_rvalid_o[i] = tag_valid_q & (tag_id_q == chan_id_e'(i));
    end
  end

  assign st_gnt_o = grant & win_store;
  assign rdata_o  = mem_r_data_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_ptr_q    <= '0;
      tag_valid_q <= 1'b0;
    end else if (clear_i) begin
      rr_ptr_q    <= '0;
      tag_valid_q <= 1'b0;
    end else begin
      // Read data comes back on the next cycle only
      tag_valid_q <= grant & ~win_store;
      if (grant) begin
        rr_ptr_q <= (rr_slot == SLOT_W'(N_SRC - 1)) ? '0 : rr_slot + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant) begin
      tag_id_q <= win_id;
    end
  end

endmodule : ldst_arbiter

//--- redmule_streamer.sv
`timescale 1ns/1ps
`include "streamer_defs.svh"

module redmule_streamer
  import streamer_pkg::*;
(
  input  logic  clk_i,
  input  logic  arst_n_i,
  input  logic  clear_i,
  input  logic  z_priority_i,
  // X load channel
  input  logic  x_start_i,
  input  addr_t x_base_i,
  input  len_t  x_len_i,
  input  len_t  x_stride_i,
  output logic  x_valid_o,
  input  logic  x_ready_i,
  output word_t x_data_o,
  output logic  x_busy_o,
  output logic  x_done_o,
  // W load channel
  input  logic  w_start_i,
  input  addr_t w_base_i,
  input  len_t  w_len_i,
  input  len_t  w_stride_i,
  output logic  w_valid_o,
  input  logic  w_ready_i,
  output word_t w_data_o,
  output logic  w_busy_o,
  output logic  w_done_o,
  // Y load channel
  input  logic  y_start_i,
  input  addr_t y_base_i,
  input  len_t  y_len_i,
  input  len_t  y_stride_i,
  output logic  y_valid_o,
  input  logic  y_ready_i,
  output word_t y_data_o,
  output logic  y_busy_o,
  output logic  y_done_o,
  // Z store channel
  input  logic  z_start_i,
  input  addr_t z_base_i,
  input  len_t  z_len_i,
  input  len_t  z_stride_i,
  input  logic  z_valid_i,
  output logic  z_ready_o,
  input  word_t z_data_i,
  output logic  z_busy_o,
  output logic  z_done_o,
  // Single-port memory
  output logic  mem_req_o,
  output addr_t mem_add_o,
  output logic  mem_wen_o,
  output word_t mem_data_o,
  input  logic  mem_gnt_i,
  input  word_t mem_r_data_i
);

  logic [`STREAMER_N_SRC-1:0]  src_req;
  addr_t [`STREAMER_N_SRC-1:0] src_add;
  logic [`STREAMER_N_SRC-1:0]  src_gnt;
  logic [`STREAMER_N_SRC-1:0]  src_rvalid;
  word_t                       rdata;
  logic                        st_req;
  store_req_t                  st_wreq;
  logic                        st_gnt;

  stream_source i_x_source (
    .clk_i, .arst_n_i, .clear_i,
    .start_i  ( x_start_i        ), .base_i  ( x_base_i         ),
    .len_i    ( x_len_i          ), .stride_i( x_stride_i       ),
    .req_o    ( src_req[CH_X]    ), .add_o   ( src_add[CH_X]    ),
    .gnt_i    ( src_gnt[CH_X]    ), .rvalid_i( src_rvalid[CH_X] ),
    .rdata_i  ( rdata            ), .valid_o ( x_valid_o        ),
    .ready_i  ( x_ready_i        ), .data_o  ( x_data_o         ),
    .busy_o   ( x_busy_o         ), .done_o  ( x_done_o         )
  );

  stream_source i_w_source (
    .clk_i, .arst_n_i, .clear_i,
    .start_i  ( w_start_i        ), .base_i  ( w_base_i         ),
    .len_i    ( w_len_i          ), .stride_i( w_stride_i       ),
    .req_o    ( src_req[CH_W]    ), .add_o   ( src_add[CH_W]    ),
    .gnt_i    ( src_gnt[CH_W]    ), .rvalid_i( src_rvalid[CH_W] ),
    .rdata_i  ( rdata            ), .valid_o ( w_valid_o        ),
    .ready_i  ( w_ready_i        ), .data_o  ( w_data_o         ),
    .busy_o   ( w_busy_o         ), .done_o  ( w_done_o         )
  );

  stream_source i_y_source (
    .clk_i, .arst_n_i, .clear_i,
    .start_i  ( y_start_i        ), .base_i  ( y_base_i         ),
    .len_i    ( y_len_i          ), .stride_i( y_stride_i       ),
    .req_o    ( src_req[CH_Y]    ), .add_o   ( src_add[CH_Y]    ),
    .gnt_i    ( src_gnt[CH_Y]    ), .rvalid_i( src_rvalid[CH_Y] ),
    .rdata_i  ( rdata            ), .valid_o ( y_valid_o        ),
    .ready_i  ( y_ready_i        ), .data_o  ( y_data_o         ),
    .busy_o   ( y_busy_o         ), .done_o  ( y_done_o         )
  );

  stream_sink i_z_sink (
    .clk_i, .arst_n_i, .clear_i,
    .start_i  ( z_start_i  ), .base_i  ( z_base_i   ),
    .len_i    ( z_len_i    ), .stride_i( z_stride_i ),
    .valid_i  ( z_valid_i  ), .ready_o ( z_ready_o  ),
    .data_i   ( z_data_i   ), .req_o   ( st_req     ),
    .wreq_o   ( st_wreq    ), .gnt_i   ( st_gnt     ),
    .busy_o   ( z_busy_o   ), .done_o  ( z_done_o   )
  );

  // Y and the store are paired inside before round-robin with X and W
  ldst_arbiter i_ldst_arbiter (
    .clk_i, .arst_n_i, .clear_i, .z_priority_i,
    .src_req_i    ( src_req      ),
    .src_add_i    ( src_add      ),
    .src_gnt_o    ( src_gnt      ),
    .src_rvalid_o ( src_rvalid   ),
    .rdata_o      ( rdata        ),
    .st_req_i     ( st_req       ),
    .st_wreq_i    ( st_wreq      ),
    .st_gnt_o     ( st_gnt       ),
    .mem_req_o    ( mem_req_o    ),
    .mem_add_o    ( mem_add_o    ),
    .mem_wen_o    ( mem_wen_o    ),
    .mem_data_o   ( mem_data_o   ),
    .mem_gnt_i    ( mem_gnt_i    ),
    .mem_r_data_i ( mem_r_data_i )
  );

endmodule : redmule_streamer

//--- tb_checker.sv
`timescale 1ns/1ps

module tb_checker
  import streamer_pkg::*;
(
  input  logic  clk_i,
  input  logic  clear_i,
  input  logic  check_idle_i,
  input  logic  x_valid_i,
  input  logic  x_ready_i,
  input  word_t x_data_i,
  input  logic  x_done_i,
  input  logic  x_busy_i,
  input  logic  w_valid_i,
  input  logic  w_ready_i,
  input  word_t w_data_i,
  input  logic  w_done_i,
  input  logic  w_busy_i,
  input  logic  y_valid_i,
  input  logic  y_ready_i,
  input  word_t y_data_i,
  input  logic  y_done_i,
  input  logic  y_busy_i,
  input  logic  z_done_i,
  input  logic  z_busy_i,
  input  logic  mem_req_i,
  output addr_t peek_addr_o,
  input  word_t peek_data_i,
  output int    err_count_o,
  output int    pass_count_o,
  output int    fail_count_o
);

  logic [2:0]       vld;
  logic [2:0]       rdy;
  logic [3:0]       dn;
  logic [3:0]       bsy;
  logic [3:0]       bsy_prev_q;
  word_t            dat [3];
  logic [3:0][15:0] base_q;
  logic [3:0][15:0] len_q;
  logic [3:0][15:0] stride_q;
  logic [2:0][31:0] first_q;
  word_t            zword_q;
  int               cnt_q [3];
  int               done_cnt_q [4];
  logic [2:0]       hold_q;
  word_t            hold_data_q [3];
  logic             armed_q = 1'b0;
  int               test_q;
  int               err_q = 0;
  int               err_mark_q = 0;
  int               pass_q = 0;
  int               fail_q = 0;
  string            names [4] = '{"x", "w", "y", "z"};

  assign vld = {y_valid_i, w_valid_i, x_valid_i};
  assign rdy = {y_ready_i, w_ready_i, x_ready_i};
  assign dn  = {z_done_i, y_done_i, w_done_i, x_done_i};
  assign bsy = {z_busy_i, y_busy_i, w_busy_i, x_busy_i};
  assign dat[0] = x_data_i;
  assign dat[1] = w_data_i;
  assign dat[2] = y_data_i;

  assign err_count_o  = err_q;
  assign pass_count_o = pass_q;
  assign fail_count_o = fail_q;

  // Memory content before any store as the memory model fills it
  function automatic word_t load_word(input addr_t a);
    return {16'h0000, a} ^ 32'h5a5a0000;
  endfunction

  function automatic addr_t run_addr(input int ch, input int k);
    logic [15:0] off;
    off = 16'(k) * stride_q[ch];
    return base_q[ch] + off;
  endfunction

  task automatic note_error(input string msg);
    $display("%s", msg);
    err_q++;
  endtask

  task automatic begin_test(input int test_no, input logic [3:0][15:0] base,
                            input logic [3:0][15:0] len, input logic [3:0][15:0] stride,
                            input logic [2:0][31:0] first, input word_t zword);
    test_q     = test_no;
    base_q     = base;
    len_q      = len;
    stride_q   = stride;
    first_q    = first;
    zword_q    = zword;
    hold_q     = '0;
    bsy_prev_q = '0;
    for (int c = 0; c < 4; c++) begin
      done_cnt_q[c] = 0;
      if (c < 3) begin
        cnt_q[c] = 0;
      end
    end
    armed_q = 1'b1;
  endtask

  always @(posedge clk_i) begin
    word_t exp;
    if (check_idle_i && ((vld != 3'b000) || mem_req_i)) begin
      note_error("valid outputs or mem_req_o still high after clear_i");
    end
    if (armed_q && !clear_i) begin
      for (int c = 0; c < 3; c++) begin
        // A stalled word must stay on the stream unchanged
        if (hold_q[c] && (!vld[c] || dat[c] !== hold_data_q[c])) begin
          note_error($sformatf("%s stream dropped or changed a word before it was accepted",
                               names[c]));
        end
        if (vld[c] && rdy[c]) begin
          if (cnt_q[c] >= int'(len_q[c])) begin
            note_error($sformatf("%s stream delivered more words than configured", names[c]));
          end else begin
            exp = (cnt_q[c] == 0) ? first_q[c] : load_word(run_addr(c, cnt_q[c]));
            if (dat[c] !== exp) begin
              note_error($sformatf("error %s_data_o: got %h expected %h (word %0d)",
                                   names[c], dat[c], exp, cnt_q[c]));
            end
          end
          cnt_q[c]++;
        end
        hold_q[c]      = vld[c] & ~rdy[c];
        hold_data_q[c] = dat[c];
      end
      for (int c = 0; c < 4; c++) begin
        if (dn[c]) begin
          done_cnt_q[c]++;
          // Busy is a level that ends together with the done pulse
          if (bsy[c]) begin
            note_error($sformatf("error %s_busy_o: got %h expected %h with done",
                                 names[c], bsy[c], 1'b0));
          end
          if (len_q[c] != '0 && !bsy_prev_q[c]) begin
            note_error($sformatf("error %s_busy_o: got %h expected %h before done",
                                 names[c], bsy_prev_q[c], 1'b1));
          end
        end
      end
      bsy_prev_q = bsy;
    end
  end

  task automatic finish_test();
    int    errs;
    word_t exp;
    for (int c = 0; c < 3; c++) begin
      if (cnt_q[c] != int'(len_q[c])) begin
        note_error($sformatf("%s stream delivered %0d of %0d words",
                             names[c], cnt_q[c], len_q[c]));
      end
    end
    for (int c = 0; c < 4; c++) begin
      if (done_cnt_q[c] != 1) begin
        note_error($sformatf("%s channel raised done %0d times", names[c], done_cnt_q[c]));
      end
    end
    // Stored words land at the strided run of the Z channel
    for (int k = 0; k < int'(len_q[3]); k++) begin
      peek_addr_o = run_addr(3, k);
      #1;
      exp = zword_q + word_t'(k);
      if (peek_data_i !== exp) begin
        note_error($sformatf("error mem[%h]: got %h expected %h",
                             peek_addr_o, peek_data_i, exp));
      end
    end
    armed_q    = 1'b0;
    errs       = err_q - err_mark_q;
    err_mark_q = err_q;
    if (errs == 0) begin
      pass_q++;
      $display("test %0d passed", test_q);
    end else begin
      fail_q++;
      $display("test %0d failed with %0d errors", test_q, errs);
    end
  endtask

endmodule : tb_checker

//--- tb_streamer.sv
`timescale 1ns/1ps

module tb_streamer
  import streamer_pkg::*;
();

  localparam int          MEM_WORDS        = 65536;
  localparam int          MAX_TESTS        = 32;
  localparam logic [31:0] SEED             = 32'ha487aa06;
  localparam int          TIMEOUT_PER_WORD = 40;
  localparam int          TIMEOUT_BASE     = 200;
  localparam string       DATA_FILE        = "streamer_testdata.txt";

  logic  clk = 1'b0;
  logic  arst_n;
  logic  clear;
  logic  check_idle;
  logic  z_priority;
  logic  x_start, w_start, y_start, z_start;
  addr_t x_base, w_base, y_base, z_base;
  len_t  x_len, w_len, y_len, z_len;
  len_t  x_stride, w_stride, y_stride, z_stride;
  logic  x_valid, w_valid, y_valid;
  logic  x_ready, w_ready, y_ready;
  word_t x_data, w_data, y_data;
  logic  x_busy, w_busy, y_busy, z_busy;
  logic  x_done, w_done, y_done, z_done;
  logic  z_valid;
  logic  z_ready;
  word_t z_data;
  logic  mem_req;
  addr_t mem_add;
  logic  mem_wen;
  word_t mem_wdata;
  logic  mem_gnt;
  word_t mem_rdata;

  word_t            mem [MEM_WORDS];
  word_t            r_data_q;
  addr_t            peek_addr;
  word_t            peek_data;
  logic [31:0]      rng;
  logic [31:0]      z_rng;
  int               err_count;
  int               pass_count;
  int               fail_count;
  int               n_tests;
  int               total_words;
  int               limit_cycles = 0;

  // Per-test configuration in channel order x, w, y, z
  logic [3:0][15:0] cfg_base   [MAX_TESTS];
  logic [3:0][15:0] cfg_len    [MAX_TESTS];
  logic [3:0][15:0] cfg_stride [MAX_TESTS];
  logic [2:0][31:0] cfg_first  [MAX_TESTS];
  logic             cfg_prio   [MAX_TESTS];
  logic             cfg_clear  [MAX_TESTS];
  word_t            cfg_zword  [MAX_TESTS];

  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  redmule_streamer i_dut (
    .clk_i (clk), .arst_n_i (arst_n), .clear_i (clear), .z_priority_i (z_priority),
    .x_start_i (x_start), .x_base_i (x_base), .x_len_i (x_len), .x_stride_i (x_stride),
    .x_valid_o (x_valid), .x_ready_i (x_ready), .x_data_o (x_data),
    .x_busy_o (x_busy), .x_done_o (x_done),
    .w_start_i (w_start), .w_base_i (w_base), .w_len_i (w_len), .w_stride_i (w_stride),
    .w_valid_o (w_valid), .w_ready_i (w_ready), .w_data_o (w_data),
    .w_busy_o (w_busy), .w_done_o (w_done),
    .y_start_i (y_start), .y_base_i (y_base), .y_len_i (y_len), .y_stride_i (y_stride),
    .y_valid_o (y_valid), .y_ready_i (y_ready), .y_data_o (y_data),
    .y_busy_o (y_busy), .y_done_o (y_done),
    .z_start_i (z_start), .z_base_i (z_base), .z_len_i (z_len), .z_stride_i (z_stride),
    .z_valid_i (z_valid), .z_ready_o (z_ready), .z_data_i (z_data),
    .z_busy_o (z_busy), .z_done_o (z_done),
    .mem_req_o (mem_req), .mem_add_o (mem_add), .mem_wen_o (mem_wen),
    .mem_data_o (mem_wdata), .mem_gnt_i (mem_gnt), .mem_r_data_i (mem_rdata)
  );

  tb_checker i_checker (
    .clk_i (clk), .clear_i (clear), .check_idle_i (check_idle),
    .x_valid_i (x_valid), .x_ready_i (x_ready), .x_data_i (x_data), .x_done_i (x_done),
    .x_busy_i (x_busy),
    .w_valid_i (w_valid), .w_ready_i (w_ready), .w_data_i (w_data), .w_done_i (w_done),
    .w_busy_i (w_busy),
    .y_valid_i (y_valid), .y_ready_i (y_ready), .y_data_i (y_data), .y_done_i (y_done),
    .y_busy_i (y_busy),
    .z_done_i (z_done), .z_busy_i (z_busy), .mem_req_i (mem_req),
    .peek_addr_o (peek_addr), .peek_data_i (peek_data),
    .err_count_o (err_count), .pass_count_o (pass_count), .fail_count_o (fail_count)
  );

  // Memory model answers reads one cycle after the grant
  always @(posedge clk) begin
    if (mem_req && mem_gnt) begin
      if (mem_wen) begin
        r_data_q <= mem[mem_add];
      end else begin
        mem[mem_add] <= mem_wdata;
      end
    end
  end

  assign mem_rdata = r_data_q;
  assign peek_data = mem[peek_addr];

  // Random grant stalls and stream back-pressure
  always @(posedge clk) begin
    #1;
    rng     = xorshift32(rng);
    x_ready = |rng[1:0];
    w_ready = |rng[3:2];
    y_ready = |rng[5:4];
    mem_gnt = |rng[7:6];
  end

  task automatic load_tests(output bit ok);
    int          fd;
    int          r;
    string       line;
    logic [31:0] f [18];
    ok          = 1'b0;
    n_tests     = 0;
    total_words = 0;
    fd = $fopen(DATA_FILE, "r");
    if (fd != 0) begin
      while ($fgets(line, fd) > 0) begin
        if (line.len() > 8 && line[0] != "#" && n_tests < MAX_TESTS) begin
          r = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                      f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
          if (r == 18) begin
            for (int c = 0; c < 4; c++) begin
              cfg_base[n_tests][c]   = f[3*c][15:0];
              cfg_len[n_tests][c]    = f[3*c+1][15:0];
              cfg_stride[n_tests][c] = f[3*c+2][15:0];
              total_words += int'(f[3*c+1][15:0]);
            end
            cfg_prio[n_tests]  = f[12][0];
            cfg_clear[n_tests] = f[13][0];
            cfg_zword[n_tests] = f[14];
            cfg_first[n_tests] = {f[17], f[16], f[15]};
            n_tests++;
          end
        end
      end
      $fclose(fd);
      ok = (n_tests > 0);
    end
  endtask

  task automatic start_channels(input int t);
    @(posedge clk);
    #1;
    z_priority = cfg_prio[t];
    x_base     = cfg_base[t][0];
    x_len      = cfg_len[t][0];
    x_stride   = cfg_stride[t][0];
    w_base     = cfg_base[t][1];
    w_len      = cfg_len[t][1];
    w_stride   = cfg_stride[t][1];
    y_base     = cfg_base[t][2];
    y_len      = cfg_len[t][2];
    y_stride   = cfg_stride[t][2];
    z_base     = cfg_base[t][3];
    z_len      = cfg_len[t][3];
    z_stride   = cfg_stride[t][3];
    {x_start, w_start, y_start, z_start} = 4'hf;
    @(posedge clk);
    #1;
    {x_start, w_start, y_start, z_start} = 4'h0;
  endtask

  task automatic drive_z(input int t);
    for (int k = 0; k < int'(cfg_len[t][3]); k++) begin
      z_rng = xorshift32(z_rng);
      // Occasional idle cycle between words
      if (z_rng[2:0] == 3'd0) begin
        @(posedge clk);
        #1;
      end
      z_valid = 1'b1;
      z_data  = cfg_zword[t] + word_t'(k);
      @(posedge clk);
      while (!z_ready) begin
        @(posedge clk);
      end
      #1;
      z_valid = 1'b0;
    end
  endtask

  task automatic run_test(input int t);
    logic [3:0] seen;
    if (cfg_clear[t]) begin
      // Abort a run part way and check the channels go idle
      start_channels(t);
      repeat (6) @(posedge clk);
      #1;
      clear = 1'b1;
      @(posedge clk);
      #1;
      clear      = 1'b0;
      check_idle = 1'b1;
      @(posedge clk);
      #1;
      check_idle = 1'b0;
    end
    i_checker.begin_test(t, cfg_base[t], cfg_len[t], cfg_stride[t], cfg_first[t],
                         cfg_zword[t]);
    start_channels(t);
    seen = 4'h0;
    fork
      drive_z(t);
      begin
        while (seen != 4'hf) begin
          @(posedge clk);
          seen = seen | {z_done, y_done, w_done, x_done};
        end
      end
    join
    @(posedge clk);
    #1;
    i_checker.finish_test();
  endtask

  initial begin : main
    bit ok;
    arst_n     = 1'b0;
    clear      = 1'b0;
    check_idle = 1'b0;
    z_priority = 1'b0;
    {x_start, w_start, y_start, z_start} = 4'h0;
    {x_base, w_base, y_base, z_base}     = '0;
    {x_len, w_len, y_len, z_len}         = '0;
    {x_stride, w_stride, y_stride, z_stride} = '0;
    {x_ready, w_ready, y_ready}          = 3'b000;
    z_valid   = 1'b0;
    z_data    = '0;
    mem_gnt   = 1'b0;
    r_data_q  = '0;
    rng       = SEED;
    z_rng     = xorshift32(SEED ^ 32'h0000ffff);
    for (int a = 0; a < MEM_WORDS; a++) begin
      mem[a] = word_t'(a) ^ 32'h5a5a0000;
    end
    load_tests(ok);
    if (!ok) begin
      $display("could not read any test from %s", DATA_FILE);
    end else begin
      limit_cycles = total_words * TIMEOUT_PER_WORD + TIMEOUT_BASE;
      repeat (2) @(posedge clk);
      #1;
      arst_n = 1'b1;
      for (int t = 0; t < n_tests; t++) begin
        run_test(t);
      end
    end
    $display("tests passed %0d, failed %0d, errors %0d", pass_count, fail_count, err_count);
    if (ok && fail_count == 0 && err_count == 0 && pass_count == n_tests) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin : watchdog
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("timeout, the run did not finish within %0d cycles", limit_cycles);
    $display("Something failed");
    $finish;
  end

endmodule : tb_streamer

//--- streamer_testdata.txt
# One test per line, all fields hex: base len stride for x w y z, z_priority, clear mid-run,
# first Z word (word k stores first+k), expected first load word for x w y
0000 000a 0001 0100 0008 0002 0200 0006 0003 8000 0005 0001 0 0 11110000 5a5a0000 5a5a0100 5a5a0200
0040 0014 0004 0300 000c 0001 0400 0010 0001 8100 0008 0002 1 0 22220000 5a5a0040 5a5a0300 5a5a0400
0500 0018 0001 0600 0018 0001 0700 0018 0001 8200 0018 0001 0 0 33330000 5a5a0500 5a5a0600 5a5a0700
0500 0018 0001 0600 0018 0001 0700 0018 0001 8300 0018 0001 1 0 44440000 5a5a0500 5a5a0600 5a5a0700
0800 001e 0001 0900 0014 0005 0a00 0012 0002 8400 000a 0003 0 1 55550000 5a5a0800 5a5a0900 5a5a0a00
0ffe 0004 ffff 0b00 0001 0000 0c00 0007 0000 8500 0001 0000 1 0 66660000 5a5a0ffe 5a5a0b00 5a5a0c00
0d00 0040 0001 0e00 0040 0001 0f00 0020 0001 8600 0030 0001 0 0 77770000 5a5a0d00 5a5a0e00 5a5a0f00
0d00 0040 0001 0e00 0040 0001 0f00 0020 0001 8700 0030 0001 1 0 88880000 5a5a0d00 5a5a0e00 5a5a0f00
0020 000c 0003 0140 0009 0007 0280 000b 0002 8800 000c 0004 1 1 99990000 5a5a0020 5a5a0140 5a5a0280

//--- redmule_streamer.f
+incdir+.
streamer_pkg.sv
streamer_fifo.sv
stream_source.sv
stream_sink.sv
ldst_arbiter.sv
redmule_streamer.sv
tb_checker.sv
tb_streamer.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_streamer
FILELIST  ?= redmule_streamer.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST)) streamer_defs.svh
EXE  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(EXE) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
